// ==== include/piece_sprites.svh ====
`ifndef PIECE_SPRITES_SVH
`define PIECE_SPRITES_SVH

// 8x8 piece bitmaps, row 0 at the top of the square
// bit n of a row is sprite column n, counted from the left edge

localparam logic [7:0] sprite_king [8] = '{
	8'b00011000, 8'b00111100, 8'b00011000, 8'b01111110,
	8'b01011010, 8'b00111100, 8'b01111110, 8'b00000000
};

localparam logic [7:0] sprite_queen [8] = '{
	8'b01011010, 8'b01011010, 8'b00111100, 8'b00011000,
	8'b00111100, 8'b01100110, 8'b01111110, 8'b00000000
};

localparam logic [7:0] sprite_bishop [8] = '{
	8'b00011000, 8'b00100100, 8'b01000010, 8'b00100100,
	8'b00011000, 8'b00011000, 8'b00111100, 8'b00000000
};

localparam logic [7:0] sprite_knight [8] = '{
	8'b00011100, 8'b00111110, 8'b01110110, 8'b00001110,
	8'b00011100, 8'b00111100, 8'b01111110, 8'b00000000
};

localparam logic [7:0] sprite_rook [8] = '{
	8'b01011010, 8'b01111110, 8'b00111100, 8'b00100100,
	8'b00100100, 8'b00111100, 8'b01111110, 8'b00000000
};

// pawns point toward the opponent, so each side has its own shape
localparam logic [7:0] sprite_pawn_w [8] = '{
	8'b00000000, 8'b00011000, 8'b00100100, 8'b00011000,
	8'b00011000, 8'b00111100, 8'b01111110, 8'b00000000
};

localparam logic [7:0] sprite_pawn_b [8] = '{
	8'b00000000, 8'b01111110, 8'b00111100, 8'b00011000,
	8'b00011000, 8'b00100100, 8'b00011000, 8'b00000000
};

`endif

// ==== source/chess_lcd_pkg.sv ====
package chess_lcd_pkg;

	// board placement on the 480x272 panel
	localparam int board_x0 = 108;
	localparam int board_y0 = 4;
	localparam int square_px = 33;
	localparam int border_px = 4;
	localparam int cell_px = 4;
	localparam int piece_count = 16;

	localparam logic [23:0] colour_light = 24'h6797CC;
	localparam logic [23:0] colour_dark = 24'h11448B;
	localparam logic [23:0] colour_border = 24'h00FE00;
	localparam logic [23:0] colour_cursor = 24'h3A9972;
	localparam logic [23:0] colour_white = 24'hFFFFFF;
	localparam logic [23:0] colour_black = 24'h000000;

	`include "piece_sprites.svh"

	typedef struct packed {
		logic [2:0] rank;
		logic [2:0] file;
	} square_t;

	// index 0 king, 1 queen, 2-3 bishops, 4-5 knights, 6-7 rooks, 8-15 pawns
	typedef struct packed {
		logic [piece_count-1:0] alive;
		square_t [piece_count-1:0] loc;
	} piece_set_t;

	typedef struct packed {
		logic [9:0] h;
		logic [8:0] v;
	} pixel_pos_t;

	typedef struct packed {
		logic hsync;
		logic vsync;
	} sync_t;

	// region_blank covers both porches and sync pulses
	typedef enum logic [1:0] {
		region_outside,
		region_border,
		region_board,
		region_blank
	} region_t;

	typedef struct packed {
		sync_t sync;
		region_t region;
		square_t square;
		logic dark;
		logic [5:0] row_off;
		logic [5:0] col_off;
	} locate_t;

	typedef struct packed {
		sync_t sync;
		region_t region;
		logic dark;
		logic on_cursor;
		logic piece_hit;
		logic piece_black;
	} occupant_t;

	function automatic logic [7:0] sprite_row(input logic [3:0] index, input logic black,
			input logic [2:0] row);
		logic [7:0] bits;
		case (index)
			4'd0: bits = sprite_king[row];
			4'd1: bits = sprite_queen[row];
			4'd2, 4'd3: bits = sprite_bishop[row];
			4'd4, 4'd5: bits = sprite_knight[row];
			4'd6, 4'd7: bits = sprite_rook[row];
			default: bits = black ? sprite_pawn_b[row] : sprite_pawn_w[row];
		endcase
		return bits;
	endfunction

endpackage

// ==== source/lcd_timing.sv ====
`timescale 1ns/1ps

module lcd_timing #(
	parameter int h_total = 526,
	parameter int v_total = 286,
	parameter int h_active = 480,
	parameter int v_active = 272,
	parameter int h_front = 2,
	parameter int v_front = 1,
	parameter int h_pulse = 1,
	parameter int v_pulse = 1
) (
	input logic clk12,
	input logic reset,
	output chess_lcd_pkg::pixel_pos_t pos,
	output chess_lcd_pkg::sync_t sync,
	output logic disp
);
	logic [9:0] h_next;
	logic [8:0] v_next;

	// next raster position, wrapping at the line and frame ends
	always_comb begin
		h_next = pos.h + 10'd1;
		v_next = pos.v;
		if (pos.h == 10'(h_total - 1)) begin
			h_next = '0;
			if (pos.v == 9'(v_total - 1)) begin
				v_next = '0;
			end else begin
				v_next = pos.v + 9'd1;
			end
		end
	end

	// syncs decoded from the next position so they line up with pos
	always_ff @(posedge clk12) begin
		if (reset) begin
			pos <= '0;
			sync <= '0;
			disp <= 1'b0;
		end else begin
			pos.h <= h_next;
			pos.v <= v_next;
			sync.hsync <= (h_next > 10'(h_active + h_front)) &&
				(h_next <= 10'(h_active + h_front + h_pulse));
			sync.vsync <= (v_next > 9'(v_active + v_front)) &&
				(v_next <= 9'(v_active + v_front + v_pulse));
			disp <= 1'b1;
		end
	end

	hsync_single_cycle: assert property (@(posedge clk12) disable iff (reset)
		sync.hsync |=> !sync.hsync);

endmodule

// ==== source/square_locator.sv ====
`timescale 1ns/1ps

module square_locator #(
	parameter int h_active = 480,
	parameter int v_active = 272
) (
	input logic clk12,
	input logic reset,
	input chess_lcd_pkg::pixel_pos_t pos,
	input chess_lcd_pkg::sync_t sync,
	output chess_lcd_pkg::locate_t loc
);
	// board and frame edges, far edges exclusive
	localparam int board_x1 = chess_lcd_pkg::board_x0 + 8 * chess_lcd_pkg::square_px;
	localparam int board_y1 = chess_lcd_pkg::board_y0 + 8 * chess_lcd_pkg::square_px;
	localparam int frame_x0 = chess_lcd_pkg::board_x0 - chess_lcd_pkg::border_px;
	localparam int frame_y0 = chess_lcd_pkg::board_y0 - chess_lcd_pkg::border_px;
	localparam int frame_x1 = board_x1 + chess_lcd_pkg::border_px;
	localparam int frame_y1 = board_y1 + chess_lcd_pkg::border_px;

	logic [9:0] dx;
	logic [8:0] dy;
	logic [9:0] file_w;
	logic [8:0] band_w;
	logic blank;
	logic in_board;
	logic in_frame;
	chess_lcd_pkg::locate_t loc_next;

	always_comb begin
		// offsets wrap outside the board, harmless since region masks them
		dx = pos.h - 10'(chess_lcd_pkg::board_x0);
		dy = pos.v - 9'(chess_lcd_pkg::board_y0);
		file_w = dx / 10'(chess_lcd_pkg::square_px);
		band_w = dy / 9'(chess_lcd_pkg::square_px);
		blank = int'(pos.h) >= h_active || int'(pos.v) >= v_active;
		in_board = int'(pos.h) >= chess_lcd_pkg::board_x0 && int'(pos.h) < board_x1 &&
			int'(pos.v) >= chess_lcd_pkg::board_y0 && int'(pos.v) < board_y1;
		in_frame = int'(pos.h) >= frame_x0 && int'(pos.h) < frame_x1 &&
			int'(pos.v) >= frame_y0 && int'(pos.v) < frame_y1;
		loc_next.sync = sync;
		if (blank) begin
			loc_next.region = chess_lcd_pkg::region_blank;
		end else if (in_board) begin
			loc_next.region = chess_lcd_pkg::region_board;
		end else if (in_frame) begin
			loc_next.region = chess_lcd_pkg::region_border;
		end else begin
			loc_next.region = chess_lcd_pkg::region_outside;
		end
		// rank 7 sits on the top row of squares
		loc_next.square.file = file_w[2:0];
		loc_next.square.rank = 3'd7 - band_w[2:0];
		loc_next.dark = file_w[0] ^ band_w[0];
		loc_next.col_off = 6'(dx % 10'(chess_lcd_pkg::square_px));
		loc_next.row_off = 6'(dy % 9'(chess_lcd_pkg::square_px));
	end

	always_ff @(posedge clk12) begin
		if (reset) begin
			loc <= '0;
		end else begin
			loc <= loc_next;
		end
	end

endmodule

// ==== source/square_occupant.sv ====
`timescale 1ns/1ps

module square_occupant (
	input logic clk12,
	input logic reset,
	input chess_lcd_pkg::locate_t loc,
	input chess_lcd_pkg::square_t cursor,
	input chess_lcd_pkg::piece_set_t white_set,
	input chess_lcd_pkg::piece_set_t black_set,
	output chess_lcd_pkg::occupant_t occ
);
	localparam int sprite_span = 8 * chess_lcd_pkg::cell_px;

	logic found;
	logic found_black;
	logic [3:0] found_idx;
	logic [7:0] row_bits;
	logic in_sprite;

	// later matches override, so black and low indices win
	always_comb begin
		found = 1'b0;
		found_black = 1'b0;
		found_idx = '0;
		for (int i = chess_lcd_pkg::piece_count - 1; i >= 0; i--) begin
			if (white_set.alive[i] && white_set.loc[i] == loc.square) begin
				found = 1'b1;
				found_black = 1'b0;
				found_idx = 4'(i);
			end
		end
		for (int i = chess_lcd_pkg::piece_count - 1; i >= 0; i--) begin
			if (black_set.alive[i] && black_set.loc[i] == loc.square) begin
				found = 1'b1;
				found_black = 1'b1;
				found_idx = 4'(i);
			end
		end
		// last pixel row and column of a square lie outside the sprite
		row_bits = chess_lcd_pkg::sprite_row(found_idx, found_black, loc.row_off[4:2]);
		in_sprite = loc.row_off < 6'(sprite_span) && loc.col_off < 6'(sprite_span);
	end

	always_ff @(posedge clk12) begin
		if (reset) begin
			occ <= '0;
		end else begin
			occ.sync <= loc.sync;
			occ.region <= loc.region;
			occ.dark <= loc.dark;
			occ.on_cursor <= loc.square == cursor;
			occ.piece_hit <= found && in_sprite && row_bits[loc.col_off[4:2]];
			occ.piece_black <= found_black;
		end
	end

endmodule

// ==== source/pixel_shader.sv ====
`timescale 1ns/1ps

module pixel_shader (
	input logic clk12,
	input logic reset,
	input chess_lcd_pkg::occupant_t occ,
	input logic player,
	output logic [23:0] bgr,
	output logic hsync,
	output logic vsync
);
	logic [23:0] colour;

	always_comb begin
		case (occ.region)
			chess_lcd_pkg::region_blank: begin
				colour = '0;
			end
			// background follows the side to move
			chess_lcd_pkg::region_outside: begin
				colour = player ? chess_lcd_pkg::colour_white : chess_lcd_pkg::colour_black;
			end
			chess_lcd_pkg::region_border: begin
				colour = chess_lcd_pkg::colour_border;
			end
			default: begin
				if (occ.piece_hit) begin
					if (occ.piece_black) begin
						colour = chess_lcd_pkg::colour_black;
					end else begin
						colour = chess_lcd_pkg::colour_white;
					end
				end else if (occ.on_cursor) begin
					colour = chess_lcd_pkg::colour_cursor;
				end else if (occ.dark) begin
					colour = chess_lcd_pkg::colour_dark;
				end else begin
					colour = chess_lcd_pkg::colour_light;
				end
			end
		endcase
	end

	// colour and syncs leave together
	always_ff @(posedge clk12) begin
		if (reset) begin
			bgr <= '0;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end else begin
			bgr <= colour;
			hsync <= occ.sync.hsync;
			vsync <= occ.sync.vsync;
		end
	end

endmodule

// ==== source/piece_finder.sv ====
`timescale 1ns/1ps

module piece_finder (
	input logic clk12,
	input logic reset,
	input logic lookup_req,
	input chess_lcd_pkg::square_t cursor,
	input chess_lcd_pkg::piece_set_t white_set,
	input chess_lcd_pkg::piece_set_t black_set,
	output logic lookup_ack,
	output logic found_piece,
	output logic [3:0] pid
);
	typedef enum logic [1:0] {
		st_idle,
		st_scan,
		st_done
	} state_t;

	state_t state;
	logic [4:0] entry;
	logic [3:0] piece_idx;
	chess_lcd_pkg::piece_set_t scan_set;
	logic hit;

	// entries 0-15 walk white 15..0, entries 16-31 walk black 15..0
	always_comb begin
		piece_idx = ~entry[3:0];
		scan_set = entry[4] ? black_set : white_set;
		hit = scan_set.alive[piece_idx] && scan_set.loc[piece_idx] == cursor;
	end

	always_ff @(posedge clk12) begin
		if (reset) begin
			state <= st_idle;
			entry <= '0;
			lookup_ack <= 1'b0;
			found_piece <= 1'b0;
			pid <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (lookup_req) begin
						entry <= '0;
						found_piece <= 1'b0;
						pid <= '0;
						state <= st_scan;
					end
				end
				st_scan: begin
					// last hit wins the priority
					if (hit) begin
						found_piece <= 1'b1;
						pid <= piece_idx;
					end
					entry <= entry + 5'd1;
					if (entry == 5'd31) begin
						lookup_ack <= 1'b1;
						state <= st_done;
					end
				end
				default: begin
					if (!lookup_req) begin
						lookup_ack <= 1'b0;
						state <= st_idle;
					end
				end
			endcase
		end
	end

	ack_falls_after_req: assert property (@(posedge clk12) disable iff (reset)
		$fell(lookup_ack) |-> $past(!lookup_req));

endmodule

// ==== source/chess_lcd.sv ====
`timescale 1ns/1ps

module chess_lcd #(
	parameter int h_total = 526,
	parameter int v_total = 286,
	parameter int h_active = 480,
	parameter int v_active = 272,
	parameter int h_front = 2,
	parameter int v_front = 1,
	parameter int h_pulse = 1,
	parameter int v_pulse = 1
) (
	input logic clk12,
	input logic reset,
	input chess_lcd_pkg::square_t cursor,
	input logic player,
	input chess_lcd_pkg::piece_set_t white_set,
	input chess_lcd_pkg::piece_set_t black_set,
	input logic lookup_req,
	output logic [23:0] bgr,
	output logic hsync,
	output logic vsync,
	output logic disp,
	output logic lookup_ack,
	output logic [3:0] pid,
	output logic found_piece
);
	chess_lcd_pkg::pixel_pos_t pos;
	chess_lcd_pkg::sync_t raster_sync;
	chess_lcd_pkg::locate_t loc;
	chess_lcd_pkg::occupant_t occ;

	// three stage raster pipe behind the counters
	lcd_timing #(
		.h_total(h_total), .v_total(v_total),
		.h_active(h_active), .v_active(v_active),
		.h_front(h_front), .v_front(v_front),
		.h_pulse(h_pulse), .v_pulse(v_pulse)
	) lcd_timing_inst (
		.clk12(clk12), .reset(reset), .pos(pos), .sync(raster_sync), .disp(disp)
	);

	square_locator #(.h_active(h_active), .v_active(v_active)) square_locator_inst (
		.clk12(clk12), .reset(reset), .pos(pos), .sync(raster_sync), .loc(loc)
	);

	square_occupant square_occupant_inst (
		.clk12(clk12), .reset(reset), .loc(loc), .cursor(cursor),
		.white_set(white_set), .black_set(black_set), .occ(occ)
	);

	pixel_shader pixel_shader_inst (
		.clk12(clk12), .reset(reset), .occ(occ), .player(player),
		.bgr(bgr), .hsync(hsync), .vsync(vsync)
	);

	// cursor lookup runs beside the raster path
	piece_finder piece_finder_inst (
		.clk12(clk12), .reset(reset), .lookup_req(lookup_req), .cursor(cursor),
		.white_set(white_set), .black_set(black_set),
		.lookup_ack(lookup_ack), .found_piece(found_piece), .pid(pid)
	);

endmodule

// ==== testbench/chess_lcd_tb.sv ====
`timescale 1ns/1ps

module chess_lcd_tb;

	localparam int h_total = 526;
	localparam int v_total = 286;
	localparam int h_active = 480;
	localparam int v_active = 272;
	localparam int hsync_h = 483;
	localparam int vsync_v = 274;
	localparam int ack_timeout = 100;

	// board geometry with near edges inclusive and far edges exclusive
	localparam int x0 = chess_lcd_pkg::board_x0;
	localparam int y0 = chess_lcd_pkg::board_y0;
	localparam int sq_px = chess_lcd_pkg::square_px;
	localparam int border_w = chess_lcd_pkg::border_px;
	localparam int x1 = x0 + 8 * sq_px;
	localparam int y1 = y0 + 8 * sq_px;
	localparam int sprite_span = 8 * chess_lcd_pkg::cell_px;

	logic clk12;
	logic reset;
	logic player;
	logic lookup_req;
	chess_lcd_pkg::square_t cursor;
	chess_lcd_pkg::piece_set_t white_set;
	chess_lcd_pkg::piece_set_t black_set;
	logic [23:0] bgr;
	logic hsync;
	logic vsync;
	logic disp;
	logic lookup_ack;
	logic [3:0] pid;
	logic found_piece;

	chess_lcd #(
		.h_total(h_total), .v_total(v_total),
		.h_active(h_active), .v_active(v_active),
		.h_front(2), .v_front(1), .h_pulse(1), .v_pulse(1)
	) chess_lcd_inst (
		.clk12(clk12), .reset(reset), .cursor(cursor), .player(player),
		.white_set(white_set), .black_set(black_set), .lookup_req(lookup_req),
		.bgr(bgr), .hsync(hsync), .vsync(vsync), .disp(disp),
		.lookup_ack(lookup_ack), .pid(pid), .found_piece(found_piece)
	);

	initial begin
		clk12 = 1'b0;
		forever #20 clk12 = ~clk12;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic expect_equal(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			stop_run($sformatf("FAILED %s: expected %0h, actual %0h", name, expected, actual));
		end
	endtask

	// black before white and lower index before higher
	function automatic void find_occupant(input chess_lcd_pkg::square_t sq, output logic found,
			output logic black, output logic [3:0] idx);
		found = 1'b0;
		black = 1'b0;
		idx = '0;
		for (int i = 0; i < chess_lcd_pkg::piece_count; i++) begin
			if (!found && black_set.alive[i] && black_set.loc[i] == sq) begin
				found = 1'b1;
				black = 1'b1;
				idx = 4'(i);
			end
		end
		for (int i = 0; i < chess_lcd_pkg::piece_count; i++) begin
			if (!found && white_set.alive[i] && white_set.loc[i] == sq) begin
				found = 1'b1;
				idx = 4'(i);
			end
		end
	endfunction

	function automatic logic [23:0] model_colour(input int h, input int v);
		int file;
		int vband;
		int col_off;
		int row_off;
		chess_lcd_pkg::square_t sq;
		logic found;
		logic black;
		logic [3:0] idx;
		logic [7:0] bits;
		if (h >= h_active || v >= v_active) begin
			return '0;
		end
		if (h < x0 - border_w || h >= x1 + border_w || v < y0 - border_w ||
				v >= y1 + border_w) begin
			return player ? chess_lcd_pkg::colour_white : chess_lcd_pkg::colour_black;
		end
		if (h < x0 || h >= x1 || v < y0 || v >= y1) begin
			return chess_lcd_pkg::colour_border;
		end
		file = (h - x0) / sq_px;
		vband = (v - y0) / sq_px;
		col_off = (h - x0) % sq_px;
		row_off = (v - y0) % sq_px;
		sq.rank = 3'(7 - vband);
		sq.file = 3'(file);
		find_occupant(sq, found, black, idx);
		if (found && row_off < sprite_span && col_off < sprite_span) begin
			bits = chess_lcd_pkg::sprite_row(idx, black, 3'(row_off / 4));
			if (bits[col_off / 4]) begin
				return black ? chess_lcd_pkg::colour_black : chess_lcd_pkg::colour_white;
			end
		end
		if (sq == cursor) begin
			return chess_lcd_pkg::colour_cursor;
		end
		if ((vband + file) % 2 == 1) begin
			return chess_lcd_pkg::colour_dark;
		end
		return chess_lcd_pkg::colour_light;
	endfunction

	function automatic chess_lcd_pkg::piece_set_t random_set();
		chess_lcd_pkg::piece_set_t s;
		s.alive = 16'($urandom);
		for (int i = 0; i < chess_lcd_pkg::piece_count; i++) begin
			s.loc[i] = 6'($urandom);
		end
		return s;
	endfunction

	// sync on the vsync rise at (0,274) and check up to the end of the next frame
	task automatic scan_frame(input string name);
		int h;
		int v;
		int n;
		logic prev;
		string where;
		prev = 1'b1;
		n = 0;
		forever begin
			@(negedge clk12);
			if (vsync && !prev) break;
			prev = vsync;
			n++;
			if (n > 2 * h_total * v_total) begin
				stop_run({name, ": no rising edge of vsync within two frames"});
			end
		end
		h = 0;
		v = vsync_v;
		for (n = 0; n < (v_total - vsync_v + v_total) * h_total; n++) begin
			if (n > 0) begin
				@(negedge clk12);
				h++;
				if (h == h_total) begin
					h = 0;
					v = (v == v_total - 1) ? 0 : v + 1;
				end
			end
			where = $sformatf("%s pixel %0d,%0d", name, h, v);
			expect_equal({where, " bgr"}, 32'(model_colour(h, v)), 32'(bgr));
			expect_equal({where, " hsync"}, 32'(h == hsync_h), 32'(hsync));
			expect_equal({where, " vsync"}, 32'(v == vsync_v), 32'(vsync));
		end
		expect_equal({name, " disp"}, 32'd1, 32'(disp));
	endtask

	task automatic run_lookup(input int n);
		chess_lcd_pkg::piece_set_t ws;
		chess_lcd_pkg::piece_set_t bs;
		chess_lcd_pkg::square_t cur;
		int idx;
		int waited;
		int hold;
		logic found;
		logic blk;
		logic [3:0] exp_pid;
		string name;
		name = $sformatf("lookup %0d", n);
		ws = random_set();
		bs = random_set();
		cur = 6'($urandom);
		// half of the lookups land on a live piece
		if ($urandom % 2 == 1) begin
			idx = int'($urandom % 16);
			if ($urandom % 2 == 1) begin
				bs.alive[idx] = 1'b1;
				cur = bs.loc[idx];
			end else begin
				ws.alive[idx] = 1'b1;
				cur = ws.loc[idx];
			end
		end
		@(posedge clk12);
		white_set <= ws;
		black_set <= bs;
		cursor <= cur;
		@(negedge clk12);
		expect_equal({name, " ack idle"}, 32'd0, 32'(lookup_ack));
		@(posedge clk12);
		lookup_req <= 1'b1;
		waited = 0;
		forever begin
			@(negedge clk12);
			if (lookup_ack) break;
			waited++;
			if (waited > ack_timeout) begin
				stop_run({name, ": lookup_ack did not rise"});
			end
		end
		find_occupant(cur, found, blk, exp_pid);
		expect_equal({name, " found_piece"}, 32'(found), 32'(found_piece));
		expect_equal({name, " pid"}, 32'(exp_pid), 32'(pid));
		hold = 1 + int'($urandom % 4);
		repeat (hold) begin
			@(negedge clk12);
			expect_equal({name, " ack held"}, 32'd1, 32'(lookup_ack));
		end
		@(posedge clk12);
		lookup_req <= 1'b0;
		waited = 0;
		forever begin
			@(negedge clk12);
			if (!lookup_ack) break;
			waited++;
			if (waited > ack_timeout) begin
				stop_run({name, ": lookup_ack did not fall after lookup_req fell"});
			end
		end
		expect_equal({name, " found_piece held"}, 32'(found), 32'(found_piece));
		expect_equal({name, " pid held"}, 32'(exp_pid), 32'(pid));
	endtask

	initial begin
		chess_lcd_pkg::piece_set_t ws;
		chess_lcd_pkg::piece_set_t bs;
		void'($urandom(32'h2f382d9a));
		reset <= 1'b1;
		lookup_req <= 1'b0;
		player <= 1'b0;
		cursor <= '0;
		white_set <= '0;
		black_set <= '0;

		for (int i = 0; i < 4; i++) begin
			@(negedge clk12);
			expect_equal("reset disp", 32'd0, 32'(disp));
			expect_equal("reset bgr", 32'd0, 32'(bgr));
			expect_equal("reset syncs", 32'd0, 32'({hsync, vsync}));
			expect_equal("reset lookup_ack", 32'd0, 32'(lookup_ack));
		end
		@(posedge clk12);
		reset <= 1'b0;
		@(negedge clk12);
		expect_equal("disp first cycle", 32'd0, 32'(disp));
		expect_equal("lookup_ack after reset", 32'd0, 32'(lookup_ack));
		@(negedge clk12);
		expect_equal("disp after reset", 32'd1, 32'(disp));

		// random sets with a few forced shared squares
		ws = random_set();
		bs = random_set();
		bs.loc[9] = ws.loc[1];
		bs.alive[9] = 1'b1;
		ws.alive[1] = 1'b1;
		ws.loc[12] = ws.loc[3];
		ws.alive[12] = 1'b1;
		ws.alive[3] = 1'b1;
		bs.loc[0] = bs.loc[5];
		bs.alive[0] = 1'b1;
		bs.alive[5] = 1'b1;
		@(posedge clk12);
		white_set <= ws;
		black_set <= bs;
		cursor <= 6'($urandom);
		player <= 1'b1;
		scan_frame("frame one");

		// empty board on the dark background
		ws = random_set();
		bs = random_set();
		ws.alive = '0;
		bs.alive = '0;
		@(posedge clk12);
		white_set <= ws;
		black_set <= bs;
		cursor <= 6'($urandom);
		player <= 1'b0;
		scan_frame("frame two");

		for (int i = 0; i < 20; i++) begin
			run_lookup(i);
		end

		$display("All tests passed");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+include
source/chess_lcd_pkg.sv
source/lcd_timing.sv
source/square_locator.sv
source/square_occupant.sv
source/pixel_shader.sv
source/piece_finder.sv
source/chess_lcd.sv
testbench/chess_lcd_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module chess_lcd_tb -o chess_lcd_sim &&
./obj_dir/chess_lcd_sim || exit 1
